// ==== all.f ====
sd_host_pkg.sv
sd_cmd_if.sv
sd_wb_regs.sv
sd_clk_div.sv
sd_cmd_master.sv
sd_cmd_serial.sv
sd_host_top.sv
sd_card_bfm.sv
tb_sd_host.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sd_host
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Done: no errors

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_sd_host.sv ====
module tb_sd_host import sd_host_pkg::*; ();

    localparam logic [1:0] MODE_OK     = 2'd0;
    localparam logic [1:0] MODE_SILENT = 2'd1;
    localparam logic [1:0] MODE_BADCRC = 2'd2;
    localparam logic [1:0] MODE_BADIDX = 2'd3;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 4000;
    localparam int CLK_LIMIT  = 1024;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] wdat;
    logic [31:0] rdat;
    logic        ack;
    logic        irq;
    logic        sd_clk;
    logic        host_cmd;
    logic        host_oe;
    logic        cmd_line;
    logic        card_cmd;
    logic        card_oe;
    logic [1:0]  card_mode;
    int          card_count;
    int          card_errors;
    logic [5:0]  card_index;
    logic [31:0] card_arg;

    int          errors;
    int          checks;
    logic        hung;

    // reference model state
    logic [3:0]  m_status;
    logic [3:0]  m_int_en;
    logic [31:0] m_resp;

    // pull-up when neither side drives
    assign cmd_line = host_oe ? host_cmd : (card_oe ? card_cmd : 1'b1);

    sd_host_top #(.DIV_W(8), .RESP_TIMEOUT(64)) u_dut (
        .wb_clk_i(clk), .rst_n_i(rst_n),
        .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(wdat),
        .sd_cmd_i(cmd_line),
        .dat_o(rdat), .ack_o(ack), .int_o(irq),
        .sd_clk_o(sd_clk), .sd_cmd_o(host_cmd), .sd_cmd_oe_o(host_oe)
    );

    sd_card_bfm u_card (
        .sd_clk_i(sd_clk), .cmd_i(cmd_line), .mode_i(card_mode),
        .cmd_o(card_cmd), .cmd_oe_o(card_oe),
        .cmd_count_o(card_count), .frame_err_o(card_errors),
        .last_index_o(card_index), .last_arg_o(card_arg)
    );

    always #5 clk = ~clk;

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input logic [8:0] got, input logic [8:0] exp);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR status: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] cmd_word(input logic [5:0] idx, input logic resp);
        logic [31:0] w;
        w = '0;
        w[CMD_INDEX_W-1:0] = idx;
        w[CMD_RESP_BIT]    = resp;
        return w;
    endfunction

    function automatic logic [5:0] rand_index();
        return 6'($urandom_range(63, 0));
    endfunction

    task automatic wb_access(input logic write, input logic [2:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n     = 0;
        rdata = '0;
        if (hung) return;
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= write;
        adr  <= addr;
        wdat <= wdata;
        do begin
            @(posedge clk);
            n++;
        end while (!ack && n < ACK_LIMIT);
        if (!ack) begin
            errors++;
            hung = 1'b1;
            $display("no ack from the register block at address %0d", addr);
        end else if (n != 2) begin
            errors++;
            $display("ack came %0d cycles after the strobe instead of one", n - 1);
        end
        rdata = rdat;
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(posedge clk);
        if (ack && !hung) begin
            errors++;
            $display("ack stayed high for more than one cycle");
        end
    endtask

    task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
        wb_access(1'b0, addr, 32'h0, data);
    endtask

    // half period of the card clock in wb_clk cycles
    task automatic check_clk_half_period(input logic [31:0] div);
        logic prev;
        int   n;
        int   len;
        if (hung) return;
        n    = 0;
        len  = 0;
        prev = sd_clk;
        do begin
            @(posedge clk);
            n++;
        end while (sd_clk === prev && n < CLK_LIMIT);
        prev = sd_clk;
        do begin
            @(posedge clk);
            n++;
            len++;
        end while (sd_clk === prev && n < CLK_LIMIT);
        if (sd_clk === prev) begin
            errors++;
            hung = 1'b1;
            $display("card clock stopped toggling");
        end
        check_word("sd_clk_o half period", 32'(len), div + 32'd1);
    endtask

    // poll until complete or timeout shows up
    task automatic wait_cmd_end(output logic [31:0] st);
        int n;
        n  = 0;
        st = '0;
        if (hung) return;
        do begin
            wb_read(REG_STATUS, st);
            n++;
        end while (st[1:0] == 2'b00 && n < POLL_LIMIT && !hung);
        if (st[1:0] == 2'b00 && !hung) begin
            errors++;
            hung = 1'b1;
            $display("command did not finish in time");
        end
    endtask

    task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg,
                           input logic resp, input logic [1:0] mode);
        logic [31:0] st;
        logic [31:0] rd;
        int          count0;
        card_mode <= mode;
        wb_write(REG_STATUS, 32'h3);
        m_status = m_status & 4'b1100;
        wb_write(REG_ARG, arg);
        count0 = card_count;
        wb_write(REG_CMD, cmd_word(idx, resp));
        wait_cmd_end(st);
        if (resp && mode == MODE_SILENT) begin
            m_status[ST_TIMEOUT] = 1'b1;
        end else begin
            m_status[ST_COMPLETE] = 1'b1;
            if (resp) begin
                m_resp = ~arg;
                if (mode == MODE_BADCRC) m_status[ST_CRC_ERR] = 1'b1;
                if (mode == MODE_BADIDX) m_status[ST_INDEX_ERR] = 1'b1;
            end
        end
        check_status(st[8:0], {5'b0, m_status});
        wb_read(REG_RESP, rd);
        check_word("REG_RESP", rd, m_resp);
        check_word("card command count", 32'(card_count - count0), 32'd1);
        check_word("card index", {26'b0, card_index}, {26'b0, idx});
        check_word("card argument", card_arg, arg);
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] st;
        logic [31:0] arg;
        logic [5:0]  idx;
        int          i;
        int          count0;
        void'($urandom(8008));
        clk = 1'b0;
        errors = 0;
        checks = 0;
        hung = 1'b0;
        m_status = '0;
        m_int_en = '0;
        m_resp = '0;
        rst_n <= 1'b0;
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        adr <= '0;
        wdat <= '0;
        card_mode <= MODE_OK;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // reset values and read back
        check_bit("sd_cmd_oe_o", host_oe, 1'b0);
        check_bit("sd_cmd_o", host_cmd, 1'b1);
        check_bit("ack_o", ack, 1'b0);
        check_bit("int_o", irq, 1'b0);
        for (i = 0; i < 6; i++) begin
            wb_read(3'(i), rd);
            check_word($sformatf("register %0d", i), rd, (3'(i) == REG_CLKDIV) ? 32'd4 : 32'd0);
        end
        repeat (4) begin
            v = $urandom;
            wb_write(REG_ARG, v);
            wb_read(REG_ARG, rd);
            check_word("REG_ARG", rd, v);
            v = $urandom;
            wb_write(REG_INT_EN, v);
            m_int_en = v[3:0];
            wb_read(REG_INT_EN, rd);
            check_word("REG_INT_EN", rd, {28'b0, v[3:0]});
            v = $urandom;
            wb_write(REG_CLKDIV, v);
            wb_read(REG_CLKDIV, rd);
            check_word("REG_CLKDIV", rd, {24'b0, v[7:0]});
        end

        // good responses over random divisors
        repeat (6) begin
            v = $urandom_range(6, 1);
            wb_write(REG_CLKDIV, v);
            check_clk_half_period(v);
            run_cmd(rand_index(), $urandom, 1'b1, MODE_OK);
        end

        run_cmd(rand_index(), $urandom, 1'b1, MODE_SILENT);
        run_cmd(rand_index(), $urandom, 1'b1, MODE_BADCRC);
        run_cmd(rand_index(), $urandom, 1'b1, MODE_BADIDX);

        // inhibit, second command dropped
        card_mode <= MODE_OK;
        wb_write(REG_STATUS, 32'hF);
        m_status = '0;
        arg = $urandom;
        idx = rand_index();
        wb_write(REG_ARG, arg);
        count0 = card_count;
        wb_write(REG_CMD, cmd_word(idx, 1'b1));
        wb_read(REG_STATUS, st);
        check_status(st[8:0], {1'b1, 4'b0000, m_status});
        wb_write(REG_CMD, cmd_word(~idx, 1'b0));
        wb_read(REG_CMD, rd);
        check_word("REG_CMD", rd, cmd_word(idx, 1'b1));
        wait_cmd_end(st);
        m_status = 4'b0001;
        m_resp = ~arg;
        check_status(st[8:0], {5'b0, m_status});
        wb_read(REG_RESP, rd);
        check_word("REG_RESP", rd, m_resp);
        check_word("card command count", 32'(card_count - count0), 32'd1);
        run_cmd(rand_index(), $urandom, 1'b0, MODE_SILENT);

        // interrupt against random enables and clears
        wb_write(REG_STATUS, 32'hF);
        m_status = '0;
        repeat (2) begin
            run_cmd(rand_index(), $urandom, 1'b1, MODE_BADCRC);
            run_cmd(rand_index(), $urandom, 1'b1, MODE_BADIDX);
            run_cmd(rand_index(), $urandom, 1'b1, MODE_SILENT);
            repeat (4) begin
                v = $urandom;
                wb_write(REG_INT_EN, v);
                m_int_en = v[3:0];
                check_bit("int_o", irq, |(m_status & m_int_en));
            end
            v = $urandom;
            wb_write(REG_STATUS, v);
            m_status = m_status & ~v[3:0];
            wb_read(REG_STATUS, rd);
            check_status(rd[8:0], {5'b0, m_status});
            check_bit("int_o", irq, |(m_status & m_int_en));
        end

        check_word("card frame errors", 32'(card_errors), 32'd0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sd_card_bfm.sv ====
module sd_card_bfm (
    input  logic        sd_clk_i,
    input  logic        cmd_i,
    input  logic [1:0]  mode_i,
    output logic        cmd_o,
    output logic        cmd_oe_o,
    output int          cmd_count_o,
    output int          frame_err_o,
    output logic [5:0]  last_index_o,
    output logic [31:0] last_arg_o
);

    // reply modes
    localparam logic [1:0] MODE_SILENT = 2'd1;
    localparam logic [1:0] MODE_BADCRC = 2'd2;
    localparam logic [1:0] MODE_BADIDX = 2'd3;

    // polynomial division over the first 40 frame bits, x^7 + x^3 + 1
    function automatic logic [6:0] frame_crc(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        int         i;
        c = '0;
        for (i = 39; i >= 0; i--) begin
            fb = c[6] ^ bits[i];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    task automatic send_response();
        logic [47:0] frame;
        logic [5:0]  idx;
        int          i;
        idx = (mode_i == MODE_BADIDX) ? last_index_o + 6'd1 : last_index_o;
        frame[47:8] = {2'b00, idx, ~last_arg_o};
        frame[7:1]  = frame_crc(frame[47:8]);
        if (mode_i == MODE_BADCRC) begin
            frame[1] = ~frame[1];
        end
        frame[0] = 1'b1;
        repeat ($urandom_range(20, 2)) @(posedge sd_clk_i);
        // card drives on falling edges, host samples on rising
        for (i = 47; i >= 0; i--) begin
            @(negedge sd_clk_i);
            cmd_oe_o <= 1'b1;
            cmd_o    <= frame[i];
        end
        @(negedge sd_clk_i);
        cmd_oe_o <= 1'b0;
        cmd_o    <= 1'b1;
    endtask

    initial begin
        logic [47:0] rx;
        int          i;
        cmd_o        <= 1'b1;
        cmd_oe_o     <= 1'b0;
        cmd_count_o  = 0;
        frame_err_o  = 0;
        last_index_o = '0;
        last_arg_o   = '0;
        forever begin
            @(posedge sd_clk_i);
            if (cmd_i === 1'b0) begin
                rx = '0;
                for (i = 0; i < 47; i++) begin
                    @(posedge sd_clk_i);
                    rx = {rx[46:0], cmd_i};
                end
                if (!rx[46] || !rx[0] || rx[7:1] != frame_crc(rx[47:8])) begin
                    frame_err_o = frame_err_o + 1;
                    $display("card got a malformed command frame %h", rx);
                end
                last_index_o = rx[45:40];
                last_arg_o   = rx[39:8];
                cmd_count_o  = cmd_count_o + 1;
                if (mode_i != MODE_SILENT) begin
                    send_response();
                end
            end
        end
    end

endmodule

// ==== sd_host_top.sv ====
module sd_host_top import sd_host_pkg::*; #(
    parameter int DIV_W        = 8,
    parameter int RESP_TIMEOUT = 64
) (
    input  logic        wb_clk_i,
    input  logic        rst_n_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [2:0]  adr_i,
    input  logic [31:0] dat_i,
    input  logic        sd_cmd_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        int_o,
    output logic        sd_clk_o,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o
);

    logic                   start;
    logic [31:0]            argument;
    logic [CMD_INDEX_W-1:0] cmd_index;
    logic                   resp_en;
    logic [DIV_W-1:0]       divisor;
    logic                   busy;
    logic                   result_valid;
    logic                   timeout;
    logic                   crc_err;
    logic                   index_err;
    logic [31:0]            resp_arg;
    logic                   sd_rise;
    logic                   sd_fall;

    sd_cmd_if u_cmd_if ();

    sd_wb_regs #(.DIV_W(DIV_W)) u_regs (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
        .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .dat_i(dat_i),
        .busy_i(busy), .result_valid_i(result_valid), .timeout_i(timeout),
        .crc_err_i(crc_err), .index_err_i(index_err), .resp_arg_i(resp_arg),
        .dat_o(dat_o), .ack_o(ack_o), .int_o(int_o), .start_o(start),
        .argument_o(argument), .cmd_index_o(cmd_index), .resp_en_o(resp_en),
        .divisor_o(divisor)
    );

    sd_clk_div #(.DIV_W(DIV_W)) u_clk_div (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .divisor_i(divisor),
        .sd_clk_o(sd_clk_o), .sd_rise_o(sd_rise), .sd_fall_o(sd_fall)
    );

    sd_cmd_master u_cmd_master (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i), .start_i(start),
        .argument_i(argument), .cmd_index_i(cmd_index), .resp_en_i(resp_en),
        .cmd(u_cmd_if.master),
        .busy_o(busy), .result_valid_o(result_valid), .timeout_o(timeout),
        .crc_err_o(crc_err), .index_err_o(index_err), .resp_arg_o(resp_arg)
    );

    sd_cmd_serial #(.RESP_TIMEOUT(RESP_TIMEOUT)) u_cmd_serial (
        .wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
        .sd_rise_i(sd_rise), .sd_fall_i(sd_fall), .sd_cmd_i(sd_cmd_i),
        .cmd(u_cmd_if.serial),
        .sd_cmd_o(sd_cmd_o), .sd_cmd_oe_o(sd_cmd_oe_o)
    );

endmodule

// ==== sd_cmd_serial.sv ====
module sd_cmd_serial import sd_host_pkg::*; #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic      wb_clk_i,
    input  logic      rst_n_i,
    input  logic      sd_rise_i,
    input  logic      sd_fall_i,
    input  logic      sd_cmd_i,
    sd_cmd_if.serial  cmd,
    output logic      sd_cmd_o,
    output logic      sd_cmd_oe_o
);

    localparam int TMO_W = $clog2(RESP_TIMEOUT + 1);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_SEND   = 3'd1;
    localparam logic [2:0] S_GAP    = 3'd2;
    localparam logic [2:0] S_WAIT   = 3'd3;
    localparam logic [2:0] S_RECV   = 3'd4;
    localparam logic [2:0] S_FINISH = 3'd5;

    logic [2:0]       state_q;
    logic [5:0]       bit_cnt_q;
    logic [TMO_W-1:0] tmo_cnt_q;
    logic             tmo_q;
    logic [39:0]      tx_q;
    logic [47:0]      rx_q;
    logic [6:0]       crc_q;
    logic             done_q;
    logic             timeout_q;
    logic             crc_err_q;
    logic             index_err_q;
    logic [31:0]      resp_arg_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            bit_cnt_q   <= '0;
            tmo_cnt_q   <= '0;
            tmo_q       <= 1'b0;
            done_q      <= 1'b0;
            timeout_q   <= 1'b0;
            crc_err_q   <= 1'b0;
            index_err_q <= 1'b0;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (cmd.start) begin
                        bit_cnt_q <= '0;
                        tmo_q     <= 1'b0;
                        state_q   <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (sd_fall_i) begin
                        if (bit_cnt_q == 6'd48) begin
                            // end bit has been sampled, release the line
                            sd_cmd_oe_o <= 1'b0;
                            sd_cmd_o    <= 1'b1;
                            bit_cnt_q   <= '0;
                            tmo_cnt_q   <= '0;
                            state_q     <= cmd.resp_en ? S_WAIT : S_GAP;
                        end else begin
                            sd_cmd_oe_o <= 1'b1;
                            bit_cnt_q   <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q < 6'd40) begin
                                sd_cmd_o <= tx_q[39];
                            end else if (bit_cnt_q < 6'd47) begin
                                sd_cmd_o <= crc_q[6];
                            end else begin
                                sd_cmd_o <= 1'b1;
                            end
                        end
                    end
                end
                S_GAP: begin
                    if (sd_fall_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 6'd7) begin
                            state_q <= S_FINISH;
                        end
                    end
                end
                S_WAIT: begin
                    if (sd_rise_i) begin
                        if (!sd_cmd_i) begin
                            bit_cnt_q <= 6'd1;
                            state_q   <= S_RECV;
                        end else if (tmo_cnt_q == TMO_W'(RESP_TIMEOUT - 1)) begin
                            tmo_q   <= 1'b1;
                            state_q <= S_FINISH;
                        end else begin
                            tmo_cnt_q <= tmo_cnt_q + 1'b1;
                        end
                    end
                end
                S_RECV: begin
                    if (sd_rise_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 6'd47) begin
                            state_q <= S_FINISH;
                        end
                    end
                end
                S_FINISH: begin
                    done_q      <= 1'b1;
                    timeout_q   <= tmo_q;
                    crc_err_q   <= cmd.resp_en & ~tmo_q & (crc_q != rx_q[7:1]);
                    index_err_q <= cmd.resp_en & ~tmo_q &
                                   (rx_q[45:40] != cmd.token.fields.index);
                    state_q     <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // shift registers and crc
    always_ff @(posedge wb_clk_i) begin
        case (state_q)
            S_IDLE: begin
                if (cmd.start) begin
                    tx_q  <= cmd.token.raw;
                    crc_q <= '0;
                end
            end
            S_SEND: begin
                if (sd_fall_i) begin
                    if (bit_cnt_q < 6'd40) begin
                        crc_q <= crc7_next(crc_q, tx_q[39]);
                        tx_q  <= {tx_q[38:0], 1'b0};
                    end else if (bit_cnt_q < 6'd47) begin
                        crc_q <= {crc_q[5:0], 1'b0};
                    end
                end
            end
            S_WAIT: begin
                if (sd_rise_i && !sd_cmd_i) begin
                    rx_q  <= {rx_q[46:0], sd_cmd_i};
                    crc_q <= crc7_next(7'd0, sd_cmd_i);
                end
            end
            S_RECV: begin
                if (sd_rise_i) begin
                    rx_q <= {rx_q[46:0], sd_cmd_i};
                    if (bit_cnt_q < 6'd40) begin
                        crc_q <= crc7_next(crc_q, sd_cmd_i);
                    end
                end
            end
            S_FINISH: resp_arg_q <= rx_q[39:8];
            default: ;
        endcase
    end

    assign cmd.done      = done_q;
    assign cmd.timeout   = timeout_q;
    assign cmd.crc_err   = crc_err_q;
    assign cmd.index_err = index_err_q;
    assign cmd.resp_arg  = resp_arg_q;

endmodule

// ==== sd_cmd_master.sv ====
module sd_cmd_master import sd_host_pkg::*; (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  logic [31:0]            argument_i,
    input  logic [CMD_INDEX_W-1:0] cmd_index_i,
    input  logic                   resp_en_i,
    sd_cmd_if.master               cmd,
    output logic                   busy_o,
    output logic                   result_valid_o,
    output logic                   timeout_o,
    output logic                   crc_err_o,
    output logic                   index_err_o,
    output logic [31:0]            resp_arg_o
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;

    logic [1:0] state_q;
    logic       start_q;
    logic       resp_en_q;
    cmd_token_u token_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= S_IDLE;
            start_q        <= 1'b0;
            resp_en_q      <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            start_q        <= 1'b0;
            result_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    resp_en_q <= resp_en_i;
                    start_q   <= 1'b1;
                    state_q   <= S_WAIT;
                end
                S_WAIT: begin
                    if (cmd.done) begin
                        result_valid_o <= 1'b1;
                        state_q        <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // token and result payload
    always_ff @(posedge wb_clk_i) begin
        if (state_q == S_ISSUE) begin
            token_q.fields.start        <= 1'b0;
            token_q.fields.transmission <= 1'b1;
            token_q.fields.index        <= cmd_index_i;
            token_q.fields.argument     <= argument_i;
        end
        if (state_q == S_WAIT && cmd.done) begin
            timeout_o   <= cmd.timeout;
            crc_err_o   <= cmd.crc_err;
            index_err_o <= cmd.index_err;
            resp_arg_o  <= cmd.resp_arg;
        end
    end

    assign cmd.start   = start_q;
    assign cmd.token   = token_q;
    assign cmd.resp_en = resp_en_q;

    // stays busy until the status update has landed
    assign busy_o = (state_q != S_IDLE) | result_valid_o;

endmodule

// ==== sd_clk_div.sv ====
module sd_clk_div #(
    parameter int DIV_W = 8
) (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,
    input  logic [DIV_W-1:0] divisor_i,
    output logic             sd_clk_o,
    output logic             sd_rise_o,
    output logic             sd_fall_o
);

    logic [DIV_W-1:0] cnt_q;

    // half period is divisor+1 wb_clk cycles
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q     <= '0;
            sd_clk_o  <= 1'b0;
            sd_rise_o <= 1'b0;
            sd_fall_o <= 1'b0;
        end else begin
            sd_rise_o <= 1'b0;
            sd_fall_o <= 1'b0;
            if (cnt_q == '0) begin
                cnt_q    <= divisor_i;
                sd_clk_o <= ~sd_clk_o;
                // tick marks the edge just produced
                if (sd_clk_o) begin
                    sd_fall_o <= 1'b1;
                end else begin
                    sd_rise_o <= 1'b1;
                end
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

// ==== sd_wb_regs.sv ====
module sd_wb_regs import sd_host_pkg::*; #(
    parameter int DIV_W = 8
) (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,
    input  logic                   cyc_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [2:0]             adr_i,
    input  logic [31:0]            dat_i,
    input  logic                   busy_i,
    input  logic                   result_valid_i,
    input  logic                   timeout_i,
    input  logic                   crc_err_i,
    input  logic                   index_err_i,
    input  logic [31:0]            resp_arg_i,
    output logic [31:0]            dat_o,
    output logic                   ack_o,
    output logic                   int_o,
    output logic                   start_o,
    output logic [31:0]            argument_o,
    output logic [CMD_INDEX_W-1:0] cmd_index_o,
    output logic                   resp_en_o,
    output logic [DIV_W-1:0]       divisor_o
);

    logic        access;
    logic        wr_en;
    logic [31:0] rd_data;
    logic [31:0] resp_q;
    logic [3:0]  status_q;
    logic [3:0]  status_set;
    logic [3:0]  status_clr;
    logic [3:0]  int_en_q;

    // one access per strobe, ack drops for a cycle in between
    assign access = cyc_i & stb_i & ~ack_o;
    assign wr_en  = access & we_i;

    always_comb begin
        status_set = '0;
        if (result_valid_i) begin
            status_set[ST_COMPLETE]  = ~timeout_i;
            status_set[ST_TIMEOUT]   = timeout_i;
            status_set[ST_CRC_ERR]   = crc_err_i;
            status_set[ST_INDEX_ERR] = index_err_i;
        end
        status_clr = (wr_en && adr_i == REG_STATUS) ? dat_i[3:0] : 4'b0;
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o       <= 1'b0;
            start_o     <= 1'b0;
            argument_o  <= '0;
            cmd_index_o <= '0;
            resp_en_o   <= 1'b0;
            resp_q      <= '0;
            status_q    <= '0;
            int_en_q    <= '0;
            divisor_o   <= DIV_W'(4);
        end else begin
            ack_o    <= access;
            start_o  <= 1'b0;
            status_q <= (status_q & ~status_clr) | status_set;
            if (wr_en) begin
                case (adr_i)
                    REG_ARG:    argument_o <= dat_i;
                    REG_INT_EN: int_en_q   <= dat_i[3:0];
                    REG_CLKDIV: divisor_o  <= dat_i[DIV_W-1:0];
                    REG_CMD: begin
                        // command held stable while the cmd path is busy
                        if (!busy_i) begin
                            cmd_index_o <= dat_i[CMD_INDEX_W-1:0];
                            resp_en_o   <= dat_i[CMD_RESP_BIT];
                            start_o     <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            if (result_valid_i && !timeout_i && resp_en_o) begin
                resp_q <= resp_arg_i;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (adr_i)
            REG_ARG:  rd_data = argument_o;
            REG_RESP: rd_data = resp_q;
            REG_CMD: begin
                rd_data[CMD_INDEX_W-1:0] = cmd_index_o;
                rd_data[CMD_RESP_BIT]    = resp_en_o;
            end
            REG_STATUS: begin
                rd_data[3:0]       = status_q;
                rd_data[ST_INHIBIT] = busy_i;
            end
            REG_INT_EN: rd_data[3:0]       = int_en_q;
            REG_CLKDIV: rd_data[DIV_W-1:0] = divisor_o;
            default: ;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            dat_o <= rd_data;
        end
    end

    assign int_o = |(status_q & int_en_q);

endmodule

// ==== sd_cmd_if.sv ====
interface sd_cmd_if import sd_host_pkg::*; ();

    // master to serial engine
    logic        start;
    cmd_token_u  token;
    logic        resp_en;

    // serial engine back to master, valid with done
    logic        done;
    logic        timeout;
    logic        crc_err;
    logic        index_err;
    logic [31:0] resp_arg;

    modport master (
        output start, token, resp_en,
        input  done, timeout, crc_err, index_err, resp_arg
    );

    modport serial (
        input  start, token, resp_en,
        output done, timeout, crc_err, index_err, resp_arg
    );

endinterface

// ==== sd_host_pkg.sv ====
package sd_host_pkg;

    // register map, word addresses
    localparam logic [2:0] REG_ARG    = 3'd0;
    localparam logic [2:0] REG_CMD    = 3'd1;
    localparam logic [2:0] REG_RESP   = 3'd2;
    localparam logic [2:0] REG_STATUS = 3'd3;
    localparam logic [2:0] REG_INT_EN = 3'd4;
    localparam logic [2:0] REG_CLKDIV = 3'd5;

    // status bit positions
    localparam int ST_COMPLETE  = 0;
    localparam int ST_TIMEOUT   = 1;
    localparam int ST_CRC_ERR   = 2;
    localparam int ST_INDEX_ERR = 3;
    localparam int ST_INHIBIT   = 8;

    localparam int CMD_INDEX_W  = 6;
    localparam int CMD_RESP_BIT = 8;

    // first 40 bits of a command frame, msb goes out first
    typedef union packed {
        struct packed {
            logic                   start;
            logic                   transmission;
            logic [CMD_INDEX_W-1:0] index;
            logic [31:0]            argument;
        } fields;
        logic [39:0] raw;
    } cmd_token_u;

    // x^7 + x^3 + 1, one bit per call
    function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

endpackage
